/* alu_issue_golden.txt */
# P cmt op wr v0 r0 rn0 v1 r1 rn1 | W rn | R rn may | M rn | B cmt | C | I n
# E cmt op (expect issue) | F full | D (drain); all fields hex
P 01 3 20 1 1 05 1 1 06
E 01 3
P 02 4 21 1 0 07 0 0 00
W 07
E 02 4
D
P 01 1 22 1 0 10 0 0 00
P 1f 2 23 1 0 10 0 0 00
P 00 5 24 1 0 10 0 0 00
P 1e 6 25 1 0 11 1 1 12
F 1
W 10
E 1f 2
E 00 5
E 01 1
F 0
P 03 8 26 1 0 11 0 0 00
W 11
E 1e 6
E 03 8
D
P 05 7 27 1 0 12 0 0 00
R 12 1
I 1
M 12
W 12
E 05 7
E 05 7
D
P 08 1 28 1 0 13 0 0 00
P 0a 2 29 1 0 13 0 0 00
P 06 3 2a 1 0 13 0 0 00
B 07
W 13
E 06 3
P 09 4 2b 1 0 14 0 0 00
C
W 14
D
P 0b 9 2c 1 1 01 0 0 00
E 0b 9

/* tb.f */
+incdir+.
iq_pkg.sv
wakeup_if.sv
flush_if.sv
alu_issue_entry.sv
alu_issue_select.sv
alu_issue_queue.sv
tb_alu_issue_queue.sv

/* Bender.yml */
package:
  name: alu_issue_queue

sources:
  - include_dirs:
      - .
    files:
      - iq_pkg.sv
      - wakeup_if.sv
      - flush_if.sv
      - alu_issue_entry.sv
      - alu_issue_select.sv
      - alu_issue_queue.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_alu_issue_queue.sv

/* tb_alu_issue_queue.sv */
/* replays the golden command file against the ALU issue queue
   and compares every issue and o_full with a cycle model of the scheduler */
`timescale 1ns/1ps
`default_nettype none
`include "iq_defs.svh"

module tb_alu_issue_queue;
  import iq_pkg::*;

  logic                     clk;
  logic                     reset_n;
  logic                     put;
  iq_entry_t                put_data;
  logic [`REL_BUS_SIZE-1:0] early_valid;
  rnid_t                    early_rnid [`REL_BUS_SIZE];
  logic [`REL_BUS_SIZE-1:0] early_may;
  logic [`TGT_BUS_SIZE-1:0] phy_valid;
  rnid_t                    phy_rnid [`TGT_BUS_SIZE];
  logic                     mis_valid;
  rnid_t                    mis_rnid;
  logic                     cflush;
  logic                     br_up;
  logic                     br_mis;
  cmt_id_t                  br_cmt;
  logic                     full;
  logic                     issue_valid;
  iq_entry_t                issue_entry;

  // model state with one slot per DUT entry
  iq_entry_t m_ent [`IQ_DEPTH];
  int        m_st [`IQ_DEPTH];   // 0 init, 1 wait, 2 issued, 3 clear
  logic      m_full;
  iq_entry_t issued [$];         // oldest issue first

  alu_issue_queue u_dut (
    .i_clk (clk), .i_reset_n (reset_n), .i_put (put), .i_put_data (put_data),
    .i_early_valid (early_valid), .i_early_rnid (early_rnid),
    .i_early_may_mispred (early_may), .i_phy_valid (phy_valid), .i_phy_rnid (phy_rnid),
    .i_mispred_valid (mis_valid), .i_mispred_rnid (mis_rnid), .i_commit_flush (cflush),
    .i_br_update (br_up), .i_br_mispredict (br_mis), .i_br_cmt_id (br_cmt),
    .o_full (full), .o_issue_valid (issue_valid), .o_issue_entry (issue_entry)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_entry(input string name, input iq_entry_t got, input iq_entry_t exp);
    if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  // a is younger than b when the wrapped distance a-b is in the lower half
  function automatic logic younger_than(input cmt_id_t a, input cmt_id_t b);
    cmt_id_t d;
    d = a - b;
    return (d != 0) && (d < (1 << (`CMT_ID_W - 1)));
  endfunction

  task automatic set_idle();
    put = 1'b0;
    put_data = '0;
    early_valid = '0;
    early_may = '0;
    phy_valid = '0;
    mis_valid = 1'b0;
    mis_rnid = '0;
    cflush = 1'b0;
    br_up = 1'b0;
    br_mis = 1'b0;
    br_cmt = '0;
    for (int p = 0; p < `REL_BUS_SIZE; p++) early_rnid[p] = '0;
    for (int p = 0; p < `TGT_BUS_SIZE; p++) phy_rnid[p] = '0;
  endtask

  // ------------------------------
  // one clock of model and checks
  // ------------------------------
  task automatic run_cycle();
    iq_entry_t nxt [`IQ_DEPTH];
    logic      rdy, pm, fl, put_fl, rel, rel_mm, phy, mh;
    int        pick, ps;
    logic      rdy_v [`IQ_DEPTH];
    logic      pm_v [`IQ_DEPTH];
    logic      fl_v [`IQ_DEPTH];
    #10;  // inputs settled since the falling edge
    pick = -1;
    ps = -1;
    put_fl = cflush || (br_up && br_mis && younger_than(put_data.cmt_id, br_cmt));
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      nxt[i] = m_ent[i];
      rdy = 1'b1;
      pm = 1'b0;
      for (int rs = 0; rs < 2; rs++) begin
        rel = 1'b0;
        rel_mm = 1'b0;
        phy = 1'b0;
        for (int p = 0; p < `REL_BUS_SIZE; p++)
          if (early_valid[p] && early_rnid[p] == m_ent[i].rd_regs[rs].rnid) begin
            rel = m_ent[i].rd_regs[rs].valid;
            rel_mm = early_may[p];
          end
        for (int p = 0; p < `TGT_BUS_SIZE; p++)
          if (phy_valid[p] && phy_rnid[p] == m_ent[i].rd_regs[rs].rnid)
            phy = m_ent[i].rd_regs[rs].valid;
        mh = m_ent[i].rd_regs[rs].valid && mis_valid && mis_rnid == m_ent[i].rd_regs[rs].rnid;
        pm = pm | (mh && (m_ent[i].rd_regs[rs].predict_ready != 0));
        if (m_ent[i].rd_regs[rs].valid && !m_ent[i].rd_regs[rs].ready &&
            m_ent[i].rd_regs[rs].predict_ready == 0) rdy = 1'b0;
        nxt[i].rd_regs[rs].ready = m_ent[i].rd_regs[rs].ready | phy | (rel & ~rel_mm);
        nxt[i].rd_regs[rs].predict_ready = {m_ent[i].rd_regs[rs].predict_ready[0] & ~mh, rel};
      end
      fl = m_ent[i].valid &&
           (cflush || (br_up && br_mis && younger_than(m_ent[i].cmt_id, br_cmt)));
      rdy_v[i] = m_ent[i].valid && m_st[i] == 1 && rdy && !pm && !fl;
      pm_v[i] = pm;
      fl_v[i] = fl;
      if (rdy_v[i] &&
          (pick < 0 || younger_than(m_ent[pick].cmt_id, m_ent[i].cmt_id))) pick = i;
    end
    check_bit("o_full", full, m_full);
    check_bit("o_issue_valid", issue_valid, pick >= 0);
    if (pick >= 0) begin
      check_entry("o_issue_entry", issue_entry, m_ent[pick]);
      issued.push_back(m_ent[pick]);
    end
    for (int i = `IQ_DEPTH - 1; i >= 0; i--)
      if (!m_ent[i].valid) ps = i;
    if (put && ps < 0) fail_run("a put was driven while every entry was occupied");
    @(posedge clk);
    m_full = 1'b1;
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      case (m_st[i])
        0: if (put && i == ps) begin
          nxt[i] = put_data;
          nxt[i].valid = 1'b1;
          m_st[i] = put_fl ? 3 : 1;
        end
        1: begin
          if (fl_v[i]) m_st[i] = 3;
          else if (i == pick) m_st[i] = 2;
        end
        2: if (fl_v[i]) m_st[i] = 3;
           else if (pm_v[i]) begin
             m_st[i] = 1;
             for (int rs = 0; rs < 2; rs++) nxt[i].rd_regs[rs].predict_ready = 2'b00;
           end else m_st[i] = 3;
        default: begin
          m_st[i] = 0;
          nxt[i].valid = 1'b0;
        end
      endcase
      m_ent[i] = nxt[i];
      m_full = m_full & nxt[i].valid;
    end
    @(negedge clk);
    set_idle();
  endtask

  // ------------------------------
  // golden command replay
  // ------------------------------
  initial begin
    int          fd, n, tries;
    string       line, cmd;
    logic [31:0] f [9];
    iq_entry_t   got;
    void'($urandom(63793));
    set_idle();
    reset_n = 1'b0;
    m_full = 1'b0;
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      m_ent[i] = '0;
      m_st[i] = 0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    fd = $fopen("alu_issue_golden.txt", "r");
    if (fd == 0) fail_run("cannot open alu_issue_golden.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      cmd = "";
      if (n > 0 && line[0] != "#")
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", cmd,
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (cmd == "P" || cmd == "R") repeat ($urandom % 4) run_cycle();
      tries = 0;
      case (cmd)
        "P": begin
          put = 1'b1;
          put_data.op = f[1][`OP_W-1:0];
          put_data.wr_rnid = rnid_t'(f[2]);
          put_data.cmt_id = cmt_id_t'(f[0]);
          put_data.rd_regs[0] = {f[3][0], f[4][0], 2'b00, rnid_t'(f[5])};
          put_data.rd_regs[1] = {f[6][0], f[7][0], 2'b00, rnid_t'(f[8])};
          run_cycle();
        end
        "W": begin
          phy_valid[0] = 1'b1;
          phy_rnid[0] = rnid_t'(f[0]);
          run_cycle();
        end
        "R": begin
          early_valid[0] = 1'b1;
          early_rnid[0] = rnid_t'(f[0]);
          early_may[0] = f[1][0];
          run_cycle();
        end
        "M": begin
          mis_valid = 1'b1;
          mis_rnid = rnid_t'(f[0]);
          run_cycle();
        end
        "B": begin
          br_up = 1'b1;
          br_mis = 1'b1;
          br_cmt = cmt_id_t'(f[0]);
          run_cycle();
        end
        "C": begin
          cflush = 1'b1;
          run_cycle();
        end
        "I": repeat (f[0]) run_cycle();
        "E": begin
          while (issued.size() == 0) begin
            tries++;
            if (tries > 50) fail_run("timeout waiting for an issue");
            run_cycle();
          end
          got = issued.pop_front();
          if (got.cmt_id !== cmt_id_t'(f[0]) || got.op !== f[1][`OP_W-1:0])
            fail_run($sformatf("[ERROR] issue cmt_id/op got %h/%h expected %h/%h",
                               got.cmt_id, got.op, f[0], f[1]));
        end
        "F": while (m_full !== f[0][0]) begin
          tries++;
          if (tries > 50) fail_run("timeout waiting for o_full to change");
          run_cycle();
        end
        "D": while ((m_ent[0].valid | m_ent[1].valid | m_ent[2].valid | m_ent[3].valid)
                    !== 1'b0) begin
          tries++;
          if (tries > 50) fail_run("timeout waiting for the queue to drain");
          run_cycle();
        end
        default: ;
      endcase
    end
    $fclose(fd);
    repeat (5) run_cycle();
    if (issued.size() != 0) begin
      fail_run("an issue came out that the golden file does not expect");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* alu_issue_queue.sv */
/* ALU issue queue top level: plain ports in, wakeup and flush buses
   bundled for the entries, one pick per cycle out */
`timescale 1ns/1ps
`default_nettype none
`include "iq_defs.svh"

module alu_issue_queue (
  input  wire                      i_clk,
  input  wire                      i_reset_n,
  input  wire                      i_put,
  input  wire iq_pkg::iq_entry_t   i_put_data,
  input  wire [`REL_BUS_SIZE-1:0]  i_early_valid,
  input  wire iq_pkg::rnid_t       i_early_rnid [`REL_BUS_SIZE],
  input  wire [`REL_BUS_SIZE-1:0]  i_early_may_mispred,
  input  wire [`TGT_BUS_SIZE-1:0]  i_phy_valid,
  input  wire iq_pkg::rnid_t       i_phy_rnid [`TGT_BUS_SIZE],
  input  wire                      i_mispred_valid,
  input  wire iq_pkg::rnid_t       i_mispred_rnid,
  input  wire                      i_commit_flush,
  input  wire                      i_br_update,
  input  wire                      i_br_mispredict,
  input  wire iq_pkg::cmt_id_t     i_br_cmt_id,
  output logic                     o_full,
  output logic                     o_issue_valid,
  output iq_pkg::iq_entry_t        o_issue_entry
);
  import iq_pkg::*;

  logic [`IQ_DEPTH-1:0] w_put_sel;
  logic [`IQ_DEPTH-1:0] w_picked;
  logic [`IQ_DEPTH-1:0] w_clear;
  logic [`IQ_DEPTH-1:0] w_valid;
  logic [`IQ_DEPTH-1:0] w_ready;
  logic [`IQ_DEPTH-1:0] w_succeeded;
  iq_entry_t            w_entries [`IQ_DEPTH];

  wakeup_if u_wk ();
  flush_if  u_fl ();

  // ----------------------------
  // bus bundling
  // ----------------------------
  assign u_wk.early_valid       = i_early_valid;
  assign u_wk.early_rnid        = i_early_rnid;
  assign u_wk.early_may_mispred = i_early_may_mispred;
  assign u_wk.phy_valid         = i_phy_valid;
  assign u_wk.phy_rnid          = i_phy_rnid;
  assign u_wk.mispred_valid     = i_mispred_valid;
  assign u_wk.mispred_rnid      = i_mispred_rnid;

  assign u_fl.commit_flush  = i_commit_flush;
  assign u_fl.br_update     = i_br_update;
  assign u_fl.br_mispredict = i_br_mispredict;
  assign u_fl.br_cmt_id     = i_br_cmt_id;

  // entry array
  for (genvar g = 0; g < `IQ_DEPTH; g++) begin : g_entry
    alu_issue_entry u_entry (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_put             (w_put_sel[g]),
      .i_put_data        (i_put_data),
      .i_entry_picked    (w_picked[g]),
      .i_clear_entry     (w_clear[g]),
      .wk_if             (u_wk),
      .fl_if             (u_fl),
      .o_entry_valid     (w_valid[g]),
      .o_entry_ready     (w_ready[g]),
      .o_entry           (w_entries[g]),
      .o_issue_succeeded (w_succeeded[g])
    );
  end

  alu_issue_select u_select (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_put             (i_put),
    .i_valid           (w_valid),
    .i_ready           (w_ready),
    .i_issue_succeeded (w_succeeded),
    .i_entries         (w_entries),
    .o_put_sel         (w_put_sel),
    .o_picked          (w_picked),
    .o_clear           (w_clear),
    .o_full            (o_full),
    .o_issue_valid     (o_issue_valid),
    .o_issue_entry     (o_issue_entry)
  );

endmodule

`default_nettype wire

/* alu_issue_select.sv */
/* slot allocation, oldest-ready pick and clear strobes for the entry array;
   also keeps the registered full flag */
`timescale 1ns/1ps
`default_nettype none
`include "iq_defs.svh"

module alu_issue_select (
  input  wire                    i_clk,
  input  wire                    i_reset_n,
  input  wire                    i_put,
  input  wire [`IQ_DEPTH-1:0]    i_valid,
  input  wire [`IQ_DEPTH-1:0]    i_ready,
  input  wire [`IQ_DEPTH-1:0]    i_issue_succeeded,
  input  wire iq_pkg::iq_entry_t i_entries [`IQ_DEPTH],
  output logic [`IQ_DEPTH-1:0]   o_put_sel,
  output logic [`IQ_DEPTH-1:0]   o_picked,
  output logic [`IQ_DEPTH-1:0]   o_clear,
  output logic                   o_full,
  output logic                   o_issue_valid,
  output iq_pkg::iq_entry_t      o_issue_entry
);
  import iq_pkg::*;

  localparam int IDX_W = $clog2(`IQ_DEPTH);

  logic [IDX_W-1:0]     w_pick_idx;
  logic [`IQ_DEPTH-1:0] w_valid_next;

  // lowest free slot takes the put
  always_comb begin
    o_put_sel = '0;
    for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
      if (!i_valid[i]) begin
        o_put_sel    = '0;
        o_put_sel[i] = i_put;
      end
    end
  end

  // ----------------------------
  // oldest ready by commit id
  // ----------------------------
  always_comb begin
    w_pick_idx    = '0;
    o_issue_valid = 1'b0;
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      if (i_ready[i] &&
          (!o_issue_valid || is_younger(i_entries[w_pick_idx].cmt_id, i_entries[i].cmt_id))) begin
        w_pick_idx    = IDX_W'(i);
        o_issue_valid = 1'b1;
      end
    end
  end

  assign o_picked      = {{(`IQ_DEPTH-1){1'b0}}, o_issue_valid} << w_pick_idx;
  assign o_issue_entry = i_entries[w_pick_idx];
  assign o_clear       = i_issue_succeeded;   // every slot in SCHED_CLEAR

  // full once no slot returns to INIT
  assign w_valid_next = (i_valid & ~o_clear) | o_put_sel;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_full <= 1'b0;
    end else begin
      o_full <= &w_valid_next;
    end
  end

endmodule

`default_nettype wire

/* alu_issue_entry.sv */
/* one ALU scheduler slot: operand wakeup, speculative predict window,
   issue state machine and flush detection; instantiated IQ_DEPTH times */
`timescale 1ns/1ps
`default_nettype none
`include "iq_defs.svh"

module alu_issue_entry (
  input  wire                    i_clk,
  input  wire                    i_reset_n,
  input  wire                    i_put,
  input  wire iq_pkg::iq_entry_t i_put_data,
  input  wire                    i_entry_picked,
  input  wire                    i_clear_entry,
  wakeup_if.slave                wk_if,
  flush_if.slave                 fl_if,
  output logic                   o_entry_valid,
  output logic                   o_entry_ready,
  output iq_pkg::iq_entry_t      o_entry,
  output logic                   o_issue_succeeded
);
  import iq_pkg::*;

  localparam int NUM_RS = 2;

  iq_entry_t    r_entry;
  iq_entry_t    w_entry_next;
  sched_state_t r_state;
  sched_state_t w_state_next;

  logic [NUM_RS-1:0] w_rel_hit;
  logic [NUM_RS-1:0] w_rel_may_mispred;
  logic [NUM_RS-1:0] w_phy_hit;
  logic [NUM_RS-1:0] w_mispred_hit;
  logic [NUM_RS-1:0] w_pred_mispred;
  logic              w_any_pred_mispred;
  logic              w_all_ready;
  logic              w_entry_flush;
  logic              w_put_flush;

  // ----------------------------
  // operand wakeup
  // ----------------------------
  always_comb begin
    for (int rs = 0; rs < NUM_RS; rs++) begin
      w_rel_hit[rs]         = 1'b0;
      w_rel_may_mispred[rs] = 1'b0;
      w_phy_hit[rs]         = 1'b0;
      for (int p = 0; p < `REL_BUS_SIZE; p++) begin
        if (wk_if.early_valid[p] && (wk_if.early_rnid[p] == r_entry.rd_regs[rs].rnid)) begin
          w_rel_hit[rs]         = r_entry.rd_regs[rs].valid;
          w_rel_may_mispred[rs] = wk_if.early_may_mispred[p];
        end
      end
      for (int p = 0; p < `TGT_BUS_SIZE; p++) begin
        if (wk_if.phy_valid[p] && (wk_if.phy_rnid[p] == r_entry.rd_regs[rs].rnid)) begin
          w_phy_hit[rs] = r_entry.rd_regs[rs].valid;
        end
      end
      w_mispred_hit[rs] = r_entry.rd_regs[rs].valid & wk_if.mispred_valid &
                          (wk_if.mispred_rnid == r_entry.rd_regs[rs].rnid);
      w_pred_mispred[rs] = w_mispred_hit[rs] & (|r_entry.rd_regs[rs].predict_ready);
    end
  end

  assign w_any_pred_mispred = |w_pred_mispred;

  // every used operand certain or inside its predict window
  always_comb begin
    w_all_ready = 1'b1;
    for (int rs = 0; rs < NUM_RS; rs++) begin
      if (r_entry.rd_regs[rs].valid &&
          !(r_entry.rd_regs[rs].ready || (|r_entry.rd_regs[rs].predict_ready))) begin
        w_all_ready = 1'b0;
      end
    end
  end

  // ----------------------------
  // flush detection
  // ----------------------------
  assign w_entry_flush = r_entry.valid &
                         (fl_if.commit_flush |
                          (fl_if.br_update & fl_if.br_mispredict &
                           is_younger(r_entry.cmt_id, fl_if.br_cmt_id)));

  // the entry being put can die in the same cycle
  assign w_put_flush = i_put &
                       (fl_if.commit_flush |
                        (fl_if.br_update & fl_if.br_mispredict &
                         is_younger(i_put_data.cmt_id, fl_if.br_cmt_id)));

  // ----------------------------
  // state machine
  // ----------------------------
  always_comb begin
    w_state_next = r_state;
    w_entry_next = r_entry;

    for (int rs = 0; rs < NUM_RS; rs++) begin
      w_entry_next.rd_regs[rs].ready = r_entry.rd_regs[rs].ready | w_phy_hit[rs] |
                                       (w_rel_hit[rs] & ~w_rel_may_mispred[rs]);
      w_entry_next.rd_regs[rs].predict_ready[0] = w_rel_hit[rs];
      w_entry_next.rd_regs[rs].predict_ready[1] = r_entry.rd_regs[rs].predict_ready[0] &
                                                  ~w_mispred_hit[rs];
    end

    case (r_state)
      INIT: begin
        if (i_put) begin
          w_entry_next       = i_put_data;
          w_entry_next.valid = 1'b1;
          w_state_next       = w_put_flush ? SCHED_CLEAR : WAIT;
        end
      end
      WAIT: begin
        if (w_entry_flush) begin
          w_state_next = SCHED_CLEAR;   // dead
        end else if (o_entry_ready && i_entry_picked) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        if (w_entry_flush) begin
          w_state_next = SCHED_CLEAR;
        end else if (w_any_pred_mispred) begin
          // speculative wakeup failed, wait for the real write
          w_state_next = WAIT;
          for (int rs = 0; rs < NUM_RS; rs++) begin
            w_entry_next.rd_regs[rs].predict_ready = 2'b00;
          end
        end else begin
          w_state_next = SCHED_CLEAR;
        end
      end
      SCHED_CLEAR: begin
        if (i_clear_entry) begin
          w_state_next       = INIT;
          w_entry_next.valid = 1'b0;
        end
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
      r_entry <= '0;
    end else begin
      r_state <= w_state_next;
      r_entry <= w_entry_next;
    end
  end

  assign o_entry_valid     = r_entry.valid;
  assign o_entry_ready     = r_entry.valid & (r_state == WAIT) & w_all_ready &
                             ~w_any_pred_mispred & ~w_entry_flush;
  assign o_entry           = r_entry;
  assign o_issue_succeeded = (r_state == SCHED_CLEAR);  // finished or dead

endmodule

`default_nettype wire

/* flush_if.sv */
/* flush notifications for the scheduler entries:
   commit flush clears everything, branch update kills younger entries */
`timescale 1ns/1ps
`default_nettype none

interface flush_if;
  import iq_pkg::*;

  logic    commit_flush;
  logic    br_update;
  logic    br_mispredict;
  cmt_id_t br_cmt_id;    // commit id of the resolved branch

  modport master (output commit_flush, br_update, br_mispredict, br_cmt_id);
  modport slave  (input  commit_flush, br_update, br_mispredict, br_cmt_id);

endinterface

`default_nettype wire

/* wakeup_if.sv */
/* wakeup buses seen by every scheduler entry: early release,
   physical write-back and the mispredict notice, all single-cycle pulses */
`timescale 1ns/1ps
`default_nettype none
`include "iq_defs.svh"

interface wakeup_if;
  import iq_pkg::*;

  logic [`REL_BUS_SIZE-1:0] early_valid;
  rnid_t                    early_rnid [`REL_BUS_SIZE];
  logic [`REL_BUS_SIZE-1:0] early_may_mispred;  // prediction may still fail
  logic [`TGT_BUS_SIZE-1:0] phy_valid;
  rnid_t                    phy_rnid [`TGT_BUS_SIZE];
  logic                     mispred_valid;
  rnid_t                    mispred_rnid;

  modport master (output early_valid, early_rnid, early_may_mispred,
                  output phy_valid, phy_rnid, mispred_valid, mispred_rnid);
  modport slave  (input  early_valid, early_rnid, early_may_mispred,
                  input  phy_valid, phy_rnid, mispred_valid, mispred_rnid);

endinterface

`default_nettype wire

/* iq_pkg.sv */
/* shared types of the ALU issue queue and the commit id age rule
   compile before the interfaces and modules that import it */
`default_nettype none
`include "iq_defs.svh"

package iq_pkg;

  typedef logic [`RNID_W-1:0]   rnid_t;
  typedef logic [`CMT_ID_W-1:0] cmt_id_t;

  typedef enum logic [1:0] {
    INIT,
    WAIT,
    ISSUED,
    SCHED_CLEAR
  } sched_state_t;

  // one source operand
  typedef struct packed {
    logic       valid;          // operand used
    logic       ready;          // value certain
    logic [1:0] predict_ready;  // [0] early hit cycle, [1] the cycle after
    rnid_t      rnid;
  } rd_reg_t;

  typedef struct packed {
    logic              valid;
    logic [`OP_W-1:0]  op;
    rnid_t             wr_rnid;
    cmt_id_t           cmt_id;
    rd_reg_t [1:0]     rd_regs;
  } iq_entry_t;

  // a younger than b when (a - b) mod 2^W is nonzero and below half the range
  function automatic logic is_younger(cmt_id_t a, cmt_id_t b);
    cmt_id_t diff;
    diff = a - b;
    return (diff != '0) && !diff[`CMT_ID_W-1];
  endfunction

endpackage

`default_nettype wire

/* iq_defs.svh */
/* sizing macros for the ALU issue queue
   include wherever queue depth, field widths or bus counts are needed */
`ifndef IQ_DEFS_SVH
`define IQ_DEFS_SVH

// queue and payload sizing
`define IQ_DEPTH      4
`define RNID_W        6
`define CMT_ID_W      5   // wraps, compare with is_younger
`define OP_W          4

// wakeup bus port counts
`define REL_BUS_SIZE  2   // early release ports
`define TGT_BUS_SIZE  2   // physical write ports

`endif
